//--- verilog/list_sel_pkg.sv
// List-selection store shared constants
// Geometry of the power-gated two-port register file and the widths of
// the producer and consumer counters

package list_sel_pkg;

    //--------------------------------------------------
    // Register-file geometry
    //--------------------------------------------------

    // Number of list entries held by the array
    localparam int RF_DEPTH = 32;

    // Address width, enough to index RF_DEPTH entries
    localparam int RF_ADDR_W = 5;

    // Logical entry width seen by the producer and consumer
    localparam int RF_DATA_W = 29;

    // Physical word width, one spare bit above the logical entry
    localparam int RF_PHYS_W = 30;

    //--------------------------------------------------
    // Counters and power gating
    //--------------------------------------------------

    // Occupancy count width, covers 0 to RF_DEPTH inclusive
    localparam int CNT_W = 6;

    // Width of the saturating dropped-push counter
    localparam int DROP_W = 8;

    // Depth of the power-switch enable chain, in clock cycles
    localparam int PG_WAKE_CYCLES = 4;

endpackage

//--- verilog/list_sel_enq.sv
// List-selection producer
// Turns push strobes into in-order register-file writes and counts
// pushes rejected while the store is full or powered down

`timescale 1ns/100ps

module list_sel_enq import list_sel_pkg::*; (
     input  logic                  wclk
    ,input  logic                  rst

    ,input  logic                  push
    ,input  logic [RF_DATA_W-1:0]  push_data

    // Status from the consumer and the register file
    ,input  logic                  full
    ,input  logic                  pwr_enable_b_out

    // Write port of the register file
    ,output logic                  we
    ,output logic [RF_ADDR_W-1:0]  waddr
    ,output logic [RF_DATA_W-1:0]  wdata

    ,output logic                  push_drop
    ,output logic [DROP_W-1:0]     drop_count
);

    //--------------------------------------------------
    // Write acceptance
    //--------------------------------------------------

    logic [RF_ADDR_W-1:0] wptr_q;
    logic                 push_rej;

    // A push lands only with room left and the array powered
    assign we       = push & ~full & ~pwr_enable_b_out;
    assign push_rej = push & (full | pwr_enable_b_out);

    // Data and address go straight to the array in the push cycle
    assign waddr = wptr_q;
    assign wdata = push_data;

    // Write pointer advances once per accepted push and wraps at the last entry
    always_ff @(posedge wclk) begin
        if (rst) begin
            wptr_q <= '0;
        end else if (we) begin
            if (wptr_q == RF_ADDR_W'(RF_DEPTH - 1))
                wptr_q <= '0;
            else
                wptr_q <= wptr_q + 1'b1;
        end
    end

    //--------------------------------------------------
    // Drop reporting
    //--------------------------------------------------

    // The drop pulse and the counter bump both show up one cycle after the push
    always_ff @(posedge wclk) begin
        if (rst) begin
            push_drop  <= 1'b0;
            drop_count <= '0;
        end else begin
            push_drop <= push_rej;
            // Counter sticks at all ones rather than wrapping back to zero
            if (push_rej && (drop_count != {DROP_W{1'b1}}))
                drop_count <= drop_count + 1'b1;
        end
    end

endmodule

//--- verilog/list_sel_rf_pg.sv
// Power-gated 32x29 two-port register file
// Behavioral array standing in for the vendor macro, with a registered
// read port, an isolation clamp on read data and a power-enable chain

`timescale 1ns/100ps

module list_sel_rf_pg import list_sel_pkg::*; (
     input  logic                  wclk
    ,input  logic                  we
    ,input  logic [RF_ADDR_W-1:0]  waddr
    ,input  logic [RF_DATA_W-1:0]  wdata

    ,input  logic                  rclk
    ,input  logic                  re
    ,input  logic [RF_ADDR_W-1:0]  raddr

    ,output logic [RF_DATA_W-1:0]  rdata

    // Power interface
    ,input  logic                  pgcb_isol_en
    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out

    ,input  logic                  rst
);

    //--------------------------------------------------
    // Power-switch enable chain
    //--------------------------------------------------

    // Active-low enable ripples through the switch segments one stage per cycle
    logic [PG_WAKE_CYCLES-1:0] pwr_chain_q;

    // Coming out of reset every segment reads as switched off
    always_ff @(posedge rclk) begin
        if (rst)
            pwr_chain_q <= '1;
        else
            pwr_chain_q <= {pwr_chain_q[PG_WAKE_CYCLES-2:0], pwr_enable_b_in};
    end

    // The last segment tells the outside world the array is fully up
    assign pwr_enable_b_out = pwr_chain_q[PG_WAKE_CYCLES-1];

    //--------------------------------------------------
    // Storage array
    //--------------------------------------------------

    logic [RF_PHYS_W-1:0] mem [RF_DEPTH];

    // Contents survive a power-down, as with retention gating, so the
    // array only stops taking writes while the chain reports it off
    always_ff @(posedge wclk) begin
        if (we && !pwr_enable_b_out) begin
            // Spare top bit is always padded with zero
            mem[waddr] <= {1'b0, wdata};
        end
    end

    //--------------------------------------------------
    // Read port
    //--------------------------------------------------

    logic [RF_PHYS_W-1:0] rdata_q;
    logic                 rd_clamp;

    // Output sits behind the isolation cells while isolated or unpowered
    assign rd_clamp = pgcb_isol_en | pwr_enable_b_out;

    // One cycle of read latency; the clamp wins over a pending read so
    // a read completing under isolation returns zero
    always_ff @(posedge rclk) begin
        if (rd_clamp)
            rdata_q <= '0;
        else if (re)
            rdata_q <= mem[raddr];
    end

    // Drop the spare bit on the way out
    assign rdata = rdata_q[RF_DATA_W-1:0];

endmodule

//--- verilog/list_sel_deq.sv
// List-selection consumer
// Holds the read pointer and occupancy count, issues register-file
// reads for accepted pops and presents the returned entries in order

`timescale 1ns/100ps

module list_sel_deq import list_sel_pkg::*; (
     input  logic                  rclk
    ,input  logic                  rst

    ,input  logic                  pop

    // Write strobe seen at the register file, used for occupancy
    ,input  logic                  we

    // Read port of the register file
    ,input  logic [RF_DATA_W-1:0]  rdata
    ,output logic                  re
    ,output logic [RF_ADDR_W-1:0]  raddr

    // Occupancy status
    ,output logic                  full
    ,output logic                  empty
    ,output logic [CNT_W-1:0]      count

    // Popped entries
    ,output logic                  pop_valid
    ,output logic [RF_DATA_W-1:0]  pop_data
    ,output logic                  pop_err
);

    //--------------------------------------------------
    // Pop acceptance and read issue
    //--------------------------------------------------

    logic [RF_ADDR_W-1:0] rptr_q;
    logic [CNT_W-1:0]     count_q;
    logic                 pop_ok;
    logic                 pop_under;

    // Any stored entry can be popped; a pop on an empty store is an underflow
    assign pop_ok    = pop & (count_q != '0);
    assign pop_under = pop & (count_q == '0);

    // Read request goes out combinationally in the pop cycle
    assign re    = pop_ok;
    assign raddr = rptr_q;

    // Read pointer steps through the array in write order and wraps
    always_ff @(posedge rclk) begin
        if (rst) begin
            rptr_q <= '0;
        end else if (pop_ok) begin
            if (rptr_q == RF_ADDR_W'(RF_DEPTH - 1))
                rptr_q <= '0;
            else
                rptr_q <= rptr_q + 1'b1;
        end
    end

    //--------------------------------------------------
    // Occupancy
    //--------------------------------------------------

    // A write and a pop in the same cycle cancel each other out
    always_ff @(posedge rclk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            case ({we, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Status flags follow the registered count, so they move one cycle after the strobe
    assign count = count_q;
    assign full  = (count_q == CNT_W'(RF_DEPTH));
    assign empty = (count_q == '0);

    //--------------------------------------------------
    // Read return path
    //--------------------------------------------------

    // First stage marks the cycle the array output holds our entry
    logic rd_vld_q;

    always_ff @(posedge rclk) begin
        if (rst) begin
            rd_vld_q  <= 1'b0;
            pop_valid <= 1'b0;
            pop_err   <= 1'b0;
        end else begin
            rd_vld_q  <= pop_ok;
            // Second stage lines up with the captured data
            pop_valid <= rd_vld_q;
            pop_err   <= pop_under;
        end
    end

    // Back-to-back pops keep two reads in flight, each captured in turn
    always_ff @(posedge rclk) begin
        if (rd_vld_q)
            pop_data <= rdata;
    end

endmodule

//--- verilog/list_sel_mem_top.sv
// List-selection store top level
// Producer writes entries into the power-gated register file and the
// consumer reads them back in first-in, first-out order

`timescale 1ns/100ps

module list_sel_mem_top import list_sel_pkg::*; (
     input  logic                  wclk
    ,input  logic                  rclk
    ,input  logic                  rst

    // Enqueue side
    ,input  logic                  push
    ,input  logic [RF_DATA_W-1:0]  push_data
    ,output logic                  push_drop
    ,output logic [DROP_W-1:0]     drop_count

    // Dequeue side
    ,input  logic                  pop
    ,output logic                  pop_valid
    ,output logic [RF_DATA_W-1:0]  pop_data
    ,output logic                  pop_err

    // Occupancy
    ,output logic                  full
    ,output logic                  empty
    ,output logic [CNT_W-1:0]      count

    // Power interface
    ,input  logic                  pgcb_isol_en
    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out
);

    //--------------------------------------------------
    // Internal buses
    //--------------------------------------------------

    // Write port, driven by the producer
    logic                 we;
    logic [RF_ADDR_W-1:0] waddr;
    logic [RF_DATA_W-1:0] wdata;

    // Read port, driven by the consumer
    logic                 re;
    logic [RF_ADDR_W-1:0] raddr;
    logic [RF_DATA_W-1:0] rdata;

    //--------------------------------------------------
    // Producer
    //--------------------------------------------------

    list_sel_enq i_enq (
         .wclk              (wclk)
        ,.rst               (rst)
        ,.push              (push)
        ,.push_data         (push_data)
        ,.full              (full)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)
        ,.push_drop         (push_drop)
        ,.drop_count        (drop_count)
    );

    //--------------------------------------------------
    // Register file
    //--------------------------------------------------

    list_sel_rf_pg i_rf (
         .wclk              (wclk)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)
        ,.rclk              (rclk)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)
        ,.pgcb_isol_en      (pgcb_isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.rst               (rst)
    );

    //--------------------------------------------------
    // Consumer
    //--------------------------------------------------

    // Consumer counts occupancy off the same write strobe the array sees
    list_sel_deq i_deq (
         .rclk              (rclk)
        ,.rst               (rst)
        ,.pop               (pop)
        ,.we                (we)
        ,.rdata             (rdata)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.full              (full)
        ,.empty             (empty)
        ,.count             (count)
        ,.pop_valid         (pop_valid)
        ,.pop_data          (pop_data)
        ,.pop_err           (pop_err)
    );

endmodule

//--- test/list_sel_mem_properties.sv
// List-selection store timing rules
// Concurrent checks on the top-level strobes, flags and power chain

`timescale 1ns/100ps

module list_sel_mem_properties import list_sel_pkg::*; (
     input  logic wclk
    ,input  logic rst
    ,input  logic push
    ,input  logic pop
    ,input  logic pop_valid
    ,input  logic push_drop
    ,input  logic full
    ,input  logic empty
    ,input  logic pwr_enable_b_in
    ,input  logic pwr_enable_b_out
);

    // Read data only comes back for a pop issued two cycles earlier
    pop_valid_follows_pop: assert property (@(posedge wclk) disable iff (rst)
        pop_valid |-> $past(pop, 2))
        else $error("pop_valid without a pop two cycles earlier");

    // Occupancy flags only move after a push or pop was seen the cycle before
    flags_need_strobe: assert property (@(posedge wclk) disable iff (rst)
        (!$stable(full) || !$stable(empty)) |-> $past(push || pop))
        else $error("full or empty changed with no push or pop");

    // A drop is only reported for a push that met a full or unpowered store
    drop_has_cause: assert property (@(posedge wclk) disable iff (rst)
        push_drop |-> $past(push && (full || pwr_enable_b_out)))
        else $error("push_drop without a rejected push");

    // Enable chain is a pure delay once reset has flushed through it
    pwr_chain_delay: assert property (@(posedge wclk) disable iff (rst)
        $past(!rst, PG_WAKE_CYCLES) |->
            (pwr_enable_b_out == $past(pwr_enable_b_in, PG_WAKE_CYCLES)))
        else $error("pwr_enable_b_out does not track pwr_enable_b_in");

endmodule

bind list_sel_mem_top list_sel_mem_properties u_props (.*);

//--- test/list_sel_mem_tb.sv
// List-selection store testbench
// Reads commands from the stimulus file, drives the top level on the
// rising clock edge and checks results against the file's expectations

`timescale 1ns/100ps

module list_sel_mem_tb import list_sel_pkg::*; ();

    //--------------------------------------------------
    // DUT signals and bookkeeping
    //--------------------------------------------------

    logic                 clk;
    logic                 rst;
    logic                 push;
    logic [RF_DATA_W-1:0] push_data;
    logic                 pop;
    logic                 pgcb_isol_en;
    logic                 pwr_enable_b_in;
    logic                 pwr_enable_b_out;
    logic                 push_drop;
    logic [DROP_W-1:0]    drop_count;
    logic                 pop_valid;
    logic [RF_DATA_W-1:0] pop_data;
    logic                 pop_err;
    logic                 full;
    logic                 empty;
    logic [CNT_W-1:0]     count;

    // Parsed stimulus lines
    string       cmd_q[$];
    logic [31:0] arg_q[$];
    logic [31:0] exp_q[$];

    // Results due at a given negedge, queued in issue order
    time                  pop_due[$];
    logic [RF_DATA_W-1:0] pop_exp[$];
    time                  err_due[$];
    time                  drop_due[$];
    logic [DROP_W-1:0]    drop_exp[$];

    int          data_errs;
    int          count_errs;
    int          flag_errs;
    int          other_errs;
    int          budget;
    logic        loaded;
    logic        run_started;
    logic        pwr_level;
    logic [15:0] lfsr;

    list_sel_mem_top UUT (
         .wclk              (clk)
        ,.rclk              (clk)
        ,.rst               (rst)
        ,.push              (push)
        ,.push_data         (push_data)
        ,.push_drop         (push_drop)
        ,.drop_count        (drop_count)
        ,.pop               (pop)
        ,.pop_valid         (pop_valid)
        ,.pop_data          (pop_data)
        ,.pop_err           (pop_err)
        ,.full              (full)
        ,.empty             (empty)
        ,.count             (count)
        ,.pgcb_isol_en      (pgcb_isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
    );

    // Both register-file ports run off this one clock, 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //--------------------------------------------------
    // Compare tasks and random gaps
    //--------------------------------------------------

    task automatic check_data(input string name, input logic [RF_DATA_W-1:0] exp,
                              input logic [RF_DATA_W-1:0] act);
        if (act !== exp) begin
            data_errs++;
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            count_errs++;
            $display("error %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_drop(input string name, input logic [DROP_W-1:0] exp,
                              input logic [DROP_W-1:0] act);
        if (act !== exp) begin
            count_errs++;
            $display("error %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("error %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Strobes last one cycle, so every edge starts by dropping them
    task automatic next_edge();
        @(posedge clk);
        push <= 1'b0;
        pop  <= 1'b0;
    endtask

    //--------------------------------------------------
    // Result monitor
    //--------------------------------------------------

    // Outputs are sampled at the falling edge, half a cycle clear of updates
    initial begin
        wait (run_started === 1'b1);
        forever begin
            @(negedge clk);
            if (pop_due.size() != 0 && pop_due[0] == $time) begin
                check_flag("pop_valid", 1'b1, pop_valid);
                check_data("pop_data", pop_exp[0], pop_data);
                void'(pop_due.pop_front());
                void'(pop_exp.pop_front());
            end else begin
                check_flag("pop_valid", 1'b0, pop_valid);
            end
            if (err_due.size() != 0 && err_due[0] == $time) begin
                check_flag("pop_err", 1'b1, pop_err);
                void'(err_due.pop_front());
            end else begin
                check_flag("pop_err", 1'b0, pop_err);
            end
            if (drop_due.size() != 0 && drop_due[0] == $time) begin
                check_flag("push_drop", 1'b1, push_drop);
                check_drop("drop_count", drop_exp[0], drop_count);
                void'(drop_due.pop_front());
                void'(drop_exp.pop_front());
            end else begin
                check_flag("push_drop", 1'b0, push_drop);
            end
        end
    end

    // Budget covers every line plus the cycles a burst or idle line expands to
    initial begin
        wait (loaded === 1'b1);
        repeat (budget) @(posedge clk);
        $display("Timeout, the stimulus did not finish within %0d cycles", budget);
        $display("CHECKS FAILED");
        $finish;
    end

    //--------------------------------------------------
    // Stimulus driver
    //--------------------------------------------------

    initial begin
        int          fd;
        string       line;
        string       cmd;
        logic [31:0] arg;
        logic [31:0] exp;
        logic [1:0]  gap;
        logic        old_pwr;

        rst             = 1'b1;
        push            = 1'b0;
        push_data       = '0;
        pop             = 1'b0;
        pgcb_isol_en    = 1'b0;
        pwr_enable_b_in = 1'b1;
        data_errs       = 0;
        count_errs      = 0;
        flag_errs       = 0;
        other_errs      = 0;
        loaded          = 1'b0;
        run_started     = 1'b0;
        pwr_level       = 1'b1;
        lfsr            = 16'd19450;
        budget          = 64;

        fd = $fopen("test/list_sel_stim.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Could not open the stimulus file test/list_sel_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    if ($sscanf(line, "%s %h %h", cmd, arg, exp) == 3) begin
                        cmd_q.push_back(cmd);
                        arg_q.push_back(arg);
                        exp_q.push_back(exp);
                        budget += 8;
                        if (cmd == "fill" || cmd == "drain" || cmd == "idle")
                            budget += int'(arg);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        // Two cycles of reset, then the idle state is checked
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_count("count", '0, count);
        check_flag("empty", 1'b1, empty);
        check_flag("full", 1'b0, full);
        check_flag("push_drop", 1'b0, push_drop);
        check_flag("pop_valid", 1'b0, pop_valid);
        check_flag("pop_err", 1'b0, pop_err);
        check_flag("pwr_enable_b_out", 1'b1, pwr_enable_b_out);
        run_started = 1'b1;

        foreach (cmd_q[i]) begin
            // Random gaps shift timing only, never an expected value
            gap = '0;
            repeat (2) begin
                lfsr = lfsr_next(lfsr);
                gap  = {gap[0], lfsr[0]};
            end
            repeat (gap) next_edge();
            arg = arg_q[i];
            exp = exp_q[i];
            case (cmd_q[i])
                "push": begin
                    next_edge();
                    push      <= 1'b1;
                    push_data <= RF_DATA_W'(arg);
                    // Nonzero expectation marks a push that should be dropped
                    if (exp != 0) begin
                        drop_due.push_back($time + 6);
                        drop_exp.push_back(DROP_W'(exp));
                    end
                end
                "pop": begin
                    next_edge();
                    pop <= 1'b1;
                    if (arg != 0) begin
                        err_due.push_back($time + 6);
                    end else begin
                        pop_due.push_back($time + 10);
                        pop_exp.push_back(RF_DATA_W'(exp));
                    end
                end
                "fill": begin
                    for (int k = 0; k < int'(arg); k++) begin
                        next_edge();
                        push      <= 1'b1;
                        push_data <= RF_DATA_W'(exp + 32'(k));
                    end
                end
                "drain": begin
                    // Back-to-back pops keep two reads in flight
                    for (int k = 0; k < int'(arg); k++) begin
                        next_edge();
                        pop <= 1'b1;
                        pop_due.push_back($time + 10);
                        pop_exp.push_back(RF_DATA_W'(exp + 32'(k)));
                    end
                end
                "count": begin
                    next_edge();
                    @(negedge clk);
                    check_count("count", CNT_W'(arg), count);
                    check_flag("empty", arg == 0, empty);
                    check_flag("full", arg == RF_DEPTH, full);
                end
                "pwr": begin
                    next_edge();
                    old_pwr         = pwr_level;
                    pwr_level       = arg[0];
                    pwr_enable_b_in <= arg[0];
                    // Output must hold for three cycles and flip on the fourth
                    repeat (PG_WAKE_CYCLES - 1) next_edge();
                    @(negedge clk);
                    check_flag("pwr_enable_b_out", old_pwr, pwr_enable_b_out);
                    next_edge();
                    @(negedge clk);
                    check_flag("pwr_enable_b_out", pwr_level, pwr_enable_b_out);
                end
                "iso": begin
                    next_edge();
                    pgcb_isol_en <= arg[0];
                end
                "idle": begin
                    repeat (arg) next_edge();
                end
                default: begin
                    other_errs++;
                    $display("Unknown command %s in the stimulus file", cmd_q[i]);
                end
            endcase
        end

        // Let the last pops and drops come back before closing
        repeat (6) next_edge();
        @(negedge clk);
        if (pop_due.size() != 0 || err_due.size() != 0 || drop_due.size() != 0) begin
            other_errs++;
            $display("Some expected results never came back from the DUT");
        end

        $display("Errors: data %0d, count %0d, flag %0d, other %0d",
                 data_errs, count_errs, flag_errs, other_errs);
        if (data_errs + count_errs + flag_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- test/list_sel_stim.txt
# Columns: command, operand (hex), expected value (hex)
# push: data, dropped-count if dropped else 0. pop: 1 for underflow, data. fill/drain: n, base
pwr 0 0
count 0 0
push 0000a01 0
push 0000a02 0
push 0000a03 0
count 3 0
pop 0 0000a01
pop 0 0000a02
pop 0 0000a03
count 0 0
pop 1 0
count 0 0
fill 20 1000000
count 20 0
push 1bad000 1
count 20 0
drain 20 1000000
count 0 0
pop 1 0
push 0000b01 0
push 0000b02 0
push 0000b03 0
count 3 0
iso 1 0
pop 0 0000000
iso 0 0
pop 0 0000b02
pop 0 0000b03
count 0 0
push 0000c01 0
push 0000c02 0
pwr 1 0
push 000dead 2
push 000c0de 3
count 2 0
pwr 0 0
pop 0 0000c01
pop 0 0000c02
count 0 0
fill 8 2000000
drain 8 2000000
count 0 0
idle 8 0

//--- flist.f
verilog/list_sel_pkg.sv
verilog/list_sel_enq.sv
verilog/list_sel_rf_pg.sv
verilog/list_sel_deq.sv
verilog/list_sel_mem_top.sv
test/list_sel_mem_properties.sv
test/list_sel_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the list-selection store simulation with Verilator.
# Pass or fail is taken from the pass message in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f flist.f \
        --top-module list_sel_mem_tb -o sim_list_sel; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_list_sel > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
